//--- hdl/exec_pkg.sv
package exec_pkg;

  // data, address and pc values.
  typedef logic [31:0] word_t;

  // register index into the integer file.
  typedef logic [4:0] reg_idx_t;

  typedef logic [2:0] funct3_t;

  // top bit set means branch compare, low bits are then the branch funct3.
  typedef logic [3:0] alu_op_t;

  // instruction bits 13:12, handed on to the CSR file.
  typedef logic [1:0] csr_kind_t;

  // major opcodes of the supported RV32I groups.
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_FENCE  = 7'b0001111,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // arithmetic and logic funct3.
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // branch conditions.
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // store widths, word is anything else.
  localparam funct3_t F3_SB   = 3'b000;
  localparam funct3_t F3_SH   = 3'b001;

  // system and fence encodings.
  localparam funct3_t F3_PRIV   = 3'b000;
  localparam funct3_t F3_FENCEI = 3'b001;

endpackage

//--- hdl/exec_alu.sv
`timescale 1ns/1ns

module exec_alu (
  input  exec_pkg::word_t   i_a,
  input  exec_pkg::word_t   i_b,
  input  exec_pkg::alu_op_t i_op,
  input  logic              i_sub,
  input  logic              i_sign,
  input  logic              i_sra,
  output exec_pkg::word_t   o_result,
  output logic              o_cmp,
  output logic              o_zero,
  output exec_pkg::word_t   o_add_r
);

  import exec_pkg::*;

  word_t       b_in;
  logic [32:0] sum;
  logic        lt_s;
  logic        lt_u;
  logic [4:0]  shamt;

  // shared adder, subtract is a + ~b + 1.
  assign b_in    = i_sub ? ~i_b : i_b;
  assign sum     = {1'b0, i_a} + {1'b0, b_in} + {32'b0, i_sub};
  assign o_add_r = sum[31:0];

  // no carry out of a - b means a < b unsigned.
  assign lt_u = !sum[32];
  // on differing signs the sign of a decides.
  assign lt_s = (i_a[31] ^ i_b[31]) ? i_a[31] : sum[31];

  assign o_cmp  = i_sign ? lt_s : lt_u;
  assign o_zero = ~|(i_a ^ i_b);

  assign shamt = i_b[4:0];

  always_comb begin
    if (i_op[3]) begin
      // compares only feed the branch decision.
      o_result = {31'b0, o_cmp};
    end else begin
      case (i_op[2:0])
        F3_ADD:  o_result = o_add_r;
        F3_SLL:  o_result = i_a << shamt;
        F3_SLT,
        F3_SLTU: o_result = {31'b0, o_cmp};
        F3_XOR:  o_result = i_a ^ i_b;
        F3_SR:   o_result = i_sra ? word_t'($signed(i_a) >>> shamt) : i_a >> shamt;
        F3_OR:   o_result = i_a | i_b;
        default: o_result = i_a & i_b;
      endcase
    end
  end

endmodule

//--- hdl/exec_decode.sv
`timescale 1ns/1ns

module exec_decode (
  input  exec_pkg::word_t     i_instr,
  input  exec_pkg::word_t     i_pc,
  input  exec_pkg::word_t     i_rs1_data,
  input  exec_pkg::word_t     i_rs2_data,
  input  exec_pkg::word_t     i_csr_data,
  input  exec_pkg::word_t     i_trap_pc,
  output exec_pkg::opcode_e   o_opcode,
  output exec_pkg::funct3_t   o_funct3,
  output exec_pkg::word_t     o_imm,
  output exec_pkg::reg_idx_t  o_rd,
  output exec_pkg::csr_kind_t o_csr_kind,
  output exec_pkg::word_t     o_alu_a,
  output exec_pkg::word_t     o_alu_b,
  output exec_pkg::alu_op_t   o_alu_op,
  output logic                o_alu_sub,
  output logic                o_alu_sign,
  output logic                o_alu_sra,
  output exec_pkg::word_t     o_store_data,
  output exec_pkg::word_t     o_target_base
);

  import exec_pkg::*;

  opcode_e opcode;
  funct3_t funct3;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_b;
  word_t   imm_u;
  word_t   imm_j;
  logic    is_alu;
  logic    is_csr_rw;

  assign opcode = opcode_e'(i_instr[6:0]);
  assign funct3 = i_instr[14:12];

  // immediate formats.
  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};
  assign imm_u = {i_instr[31:12], 12'b0};
  assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                  i_instr[30:21], 1'b0};

  assign is_alu    = (opcode == OPC_OP) || (opcode == OPC_OP_IMM);
  assign is_csr_rw = (opcode == OPC_SYSTEM) && (funct3 != F3_PRIV);

  assign o_opcode     = opcode;
  assign o_funct3     = funct3;
  assign o_rd         = i_instr[11:7];
  assign o_csr_kind   = i_instr[13:12];
  assign o_store_data = i_rs2_data;

  always_comb begin
    case (opcode)
      OPC_STORE:            o_imm = imm_s;
      OPC_BRANCH:           o_imm = imm_b;
      OPC_LUI, OPC_AUIPC:   o_imm = imm_u;
      OPC_JAL:              o_imm = imm_j;
      default:              o_imm = imm_i;
    endcase
  end

  // operand selection.
  always_comb begin
    o_alu_a = i_rs1_data;
    o_alu_b = o_imm;
    case (opcode)
      OPC_JAL, OPC_JALR: begin
        // link value pc + 4.
        o_alu_a = i_pc;
        o_alu_b = 32'd4;
      end
      OPC_LUI: begin
        o_alu_a = '0;
      end
      OPC_AUIPC: begin
        o_alu_a = i_pc;
      end
      OPC_OP, OPC_BRANCH: begin
        o_alu_b = i_rs2_data;
      end
      OPC_SYSTEM: begin
        if (is_csr_rw) begin
          // old csr value goes to rd.
          o_alu_a = '0;
          o_alu_b = i_csr_data;
        end
      end
      default: begin
        o_alu_b = o_imm;
      end
    endcase
  end

  always_comb begin
    if (is_alu) begin
      o_alu_op = {1'b0, funct3};
    end else if (opcode == OPC_BRANCH) begin
      o_alu_op = {1'b1, funct3};
    end else begin
      o_alu_op = {1'b0, F3_ADD};
    end
  end

  // sub for SUB, set-less-than and every branch compare.
  assign o_alu_sub = (opcode == OPC_BRANCH) ||
                     (is_alu && (funct3 == F3_SLT || funct3 == F3_SLTU)) ||
                     ((opcode == OPC_OP) && (funct3 == F3_ADD) && i_instr[30]);

  assign o_alu_sign = (is_alu && (funct3 == F3_SLT)) ||
                      ((opcode == OPC_BRANCH) && (funct3 == F3_BLT || funct3 == F3_BGE));

  // only looked at by the alu for right shifts.
  assign o_alu_sra = i_instr[30];

  always_comb begin
    case (opcode)
      OPC_SYSTEM: o_target_base = i_trap_pc;
      OPC_JALR:   o_target_base = i_rs1_data;
      default:    o_target_base = i_pc;
    endcase
  end

endmodule

//--- hdl/exec_stage.sv
`timescale 1ns/1ns

module exec_stage (
  input  logic                i_clock,
  input  logic                i_reset,
  input  logic                i_valid,
  input  exec_pkg::word_t     i_pc,
  input  exec_pkg::opcode_e   i_opcode,
  input  exec_pkg::funct3_t   i_funct3,
  input  exec_pkg::word_t     i_imm,
  input  exec_pkg::reg_idx_t  i_rd,
  input  exec_pkg::csr_kind_t i_csr_kind,
  input  exec_pkg::word_t     i_alu_a,
  input  exec_pkg::word_t     i_alu_b,
  input  exec_pkg::alu_op_t   i_alu_op,
  input  logic                i_alu_sub,
  input  logic                i_alu_sign,
  input  logic                i_alu_sra,
  input  exec_pkg::word_t     i_store_data,
  input  exec_pkg::word_t     i_target_base,
  input  exec_pkg::word_t     i_alu_result,
  input  logic                i_cmp,
  input  logic                i_zero,
  input  exec_pkg::word_t     i_add_r,
  output exec_pkg::word_t     o_alu_a,
  output exec_pkg::word_t     o_alu_b,
  output exec_pkg::alu_op_t   o_alu_op,
  output logic                o_alu_sub,
  output logic                o_alu_sign,
  output logic                o_alu_sra,
  output logic                o_valid,
  output exec_pkg::word_t     o_result,
  output exec_pkg::word_t     o_mem_addr,
  output exec_pkg::word_t     o_mem_wdata,
  output logic                o_mem_ren,
  output logic                o_mem_wen,
  output logic [3:0]          o_mem_wmask,
  output exec_pkg::funct3_t   o_mem_read_t,
  output logic                o_reg_wen,
  output exec_pkg::reg_idx_t  o_rd,
  output logic                o_csr_wen,
  output exec_pkg::csr_kind_t o_csr_kind,
  output logic                o_jump,
  output exec_pkg::word_t     o_target,
  output logic                o_fencei,
  output logic                o_illegal,
  output exec_pkg::word_t     o_pc
);

  import exec_pkg::*;

  logic    accept;
  opcode_e opcode_r;
  funct3_t funct3_r;
  word_t   imm_r;
  word_t   base_r;
  logic    is_load;
  logic    is_store;
  logic    is_branch;
  logic    legal;
  logic    taken;
  logic    trap;

  // a strobe is taken only while the output slot is empty.
  assign accept = i_valid && !o_valid;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= accept;
    end
  end

  always_ff @(posedge i_clock) begin
    if (accept) begin
      opcode_r    <= i_opcode;
      funct3_r    <= i_funct3;
      imm_r       <= i_imm;
      base_r      <= i_target_base;
      o_rd        <= i_rd;
      o_csr_kind  <= i_csr_kind;
      o_mem_wdata <= i_store_data;
      o_pc        <= i_pc;
      o_alu_a     <= i_alu_a;
      o_alu_b     <= i_alu_b;
      o_alu_op    <= i_alu_op;
      o_alu_sub   <= i_alu_sub;
      o_alu_sign  <= i_alu_sign;
      o_alu_sra   <= i_alu_sra;
    end
  end

  always_comb begin
    case (opcode_r)
      OPC_OP_IMM, OPC_OP, OPC_LOAD, OPC_STORE, OPC_JAL, OPC_JALR,
      OPC_AUIPC, OPC_LUI, OPC_BRANCH, OPC_SYSTEM, OPC_FENCE: legal = 1'b1;
      default: legal = 1'b0;
    endcase
  end

  assign is_load   = opcode_r == OPC_LOAD;
  assign is_store  = opcode_r == OPC_STORE;
  assign is_branch = opcode_r == OPC_BRANCH;
  assign trap      = (opcode_r == OPC_SYSTEM) && (funct3_r == F3_PRIV);

  // branch decision from the compare flags.
  always_comb begin
    case (o_alu_op)
      {1'b1, F3_BEQ}:                   taken = i_zero;
      {1'b1, F3_BNE}:                   taken = !i_zero;
      {1'b1, F3_BLT}, {1'b1, F3_BLTU}:  taken = i_cmp;
      {1'b1, F3_BGE}, {1'b1, F3_BGEU}:  taken = !i_cmp;
      default:                          taken = 1'b0;
    endcase
  end

  assign o_result     = i_alu_result;
  assign o_mem_addr   = i_add_r;
  assign o_target     = base_r + imm_r;
  assign o_mem_read_t = is_load ? funct3_r : '0;

  assign o_mem_ren = o_valid && is_load;
  assign o_mem_wen = o_valid && is_store;

  always_comb begin
    if (!o_mem_wen) begin
      o_mem_wmask = 4'b0000;
    end else if (funct3_r == F3_SB) begin
      o_mem_wmask = 4'b0001;
    end else if (funct3_r == F3_SH) begin
      o_mem_wmask = 4'b0011;
    end else begin
      o_mem_wmask = 4'b1111;
    end
  end

  assign o_reg_wen = o_valid && legal && !(is_store || is_branch);
  assign o_csr_wen = o_valid && (opcode_r == OPC_SYSTEM);
  assign o_jump    = o_valid && ((opcode_r == OPC_JAL) || (opcode_r == OPC_JALR) ||
                                 (is_branch && taken) || trap);
  assign o_fencei  = o_valid && (opcode_r == OPC_FENCE) && (funct3_r == F3_FENCEI);
  assign o_illegal = o_valid && !legal;

endmodule

//--- hdl/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
  input  logic                i_clock,
  input  logic                i_reset,
  input  logic                i_valid,
  input  exec_pkg::word_t     i_instr,
  input  exec_pkg::word_t     i_pc,
  input  exec_pkg::word_t     i_rs1_data,
  input  exec_pkg::word_t     i_rs2_data,
  input  exec_pkg::word_t     i_csr_data,
  input  exec_pkg::word_t     i_trap_pc,
  output logic                o_valid,
  output exec_pkg::word_t     o_result,
  output exec_pkg::word_t     o_mem_addr,
  output exec_pkg::word_t     o_mem_wdata,
  output logic                o_mem_ren,
  output logic                o_mem_wen,
  output logic [3:0]          o_mem_wmask,
  output exec_pkg::funct3_t   o_mem_read_t,
  output logic                o_reg_wen,
  output exec_pkg::reg_idx_t  o_rd,
  output logic                o_csr_wen,
  output exec_pkg::csr_kind_t o_csr_kind,
  output logic                o_jump,
  output exec_pkg::word_t     o_target,
  output logic                o_fencei,
  output logic                o_illegal,
  output exec_pkg::word_t     o_pc
);

  import exec_pkg::*;

  // decoder to stage.
  opcode_e   dec_opcode;
  funct3_t   dec_funct3;
  word_t     dec_imm;
  reg_idx_t  dec_rd;
  csr_kind_t dec_csr_kind;
  word_t     dec_alu_a;
  word_t     dec_alu_b;
  alu_op_t   dec_alu_op;
  logic      dec_alu_sub;
  logic      dec_alu_sign;
  logic      dec_alu_sra;
  word_t     dec_store_data;
  word_t     dec_target_base;

  // stage to alu and back.
  word_t     alu_a;
  word_t     alu_b;
  alu_op_t   alu_op;
  logic      alu_sub;
  logic      alu_sign;
  logic      alu_sra;
  word_t     alu_result;
  logic      alu_cmp;
  logic      alu_zero;
  word_t     alu_add_r;

  exec_decode u_decode (
    .i_instr       (i_instr),
    .i_pc          (i_pc),
    .i_rs1_data    (i_rs1_data),
    .i_rs2_data    (i_rs2_data),
    .i_csr_data    (i_csr_data),
    .i_trap_pc     (i_trap_pc),
    .o_opcode      (dec_opcode),
    .o_funct3      (dec_funct3),
    .o_imm         (dec_imm),
    .o_rd          (dec_rd),
    .o_csr_kind    (dec_csr_kind),
    .o_alu_a       (dec_alu_a),
    .o_alu_b       (dec_alu_b),
    .o_alu_op      (dec_alu_op),
    .o_alu_sub     (dec_alu_sub),
    .o_alu_sign    (dec_alu_sign),
    .o_alu_sra     (dec_alu_sra),
    .o_store_data  (dec_store_data),
    .o_target_base (dec_target_base)
  );

  exec_stage u_stage (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_valid       (i_valid),
    .i_pc          (i_pc),
    .i_opcode      (dec_opcode),
    .i_funct3      (dec_funct3),
    .i_imm         (dec_imm),
    .i_rd          (dec_rd),
    .i_csr_kind    (dec_csr_kind),
    .i_alu_a       (dec_alu_a),
    .i_alu_b       (dec_alu_b),
    .i_alu_op      (dec_alu_op),
    .i_alu_sub     (dec_alu_sub),
    .i_alu_sign    (dec_alu_sign),
    .i_alu_sra     (dec_alu_sra),
    .i_store_data  (dec_store_data),
    .i_target_base (dec_target_base),
    .i_alu_result  (alu_result),
    .i_cmp         (alu_cmp),
    .i_zero        (alu_zero),
    .i_add_r       (alu_add_r),
    .o_alu_a       (alu_a),
    .o_alu_b       (alu_b),
    .o_alu_op      (alu_op),
    .o_alu_sub     (alu_sub),
    .o_alu_sign    (alu_sign),
    .o_alu_sra     (alu_sra),
    .o_valid       (o_valid),
    .o_result      (o_result),
    .o_mem_addr    (o_mem_addr),
    .o_mem_wdata   (o_mem_wdata),
    .o_mem_ren     (o_mem_ren),
    .o_mem_wen     (o_mem_wen),
    .o_mem_wmask   (o_mem_wmask),
    .o_mem_read_t  (o_mem_read_t),
    .o_reg_wen     (o_reg_wen),
    .o_rd          (o_rd),
    .o_csr_wen     (o_csr_wen),
    .o_csr_kind    (o_csr_kind),
    .o_jump        (o_jump),
    .o_target      (o_target),
    .o_fencei      (o_fencei),
    .o_illegal     (o_illegal),
    .o_pc          (o_pc)
  );

  exec_alu u_alu (
    .i_a      (alu_a),
    .i_b      (alu_b),
    .i_op     (alu_op),
    .i_sub    (alu_sub),
    .i_sign   (alu_sign),
    .i_sra    (alu_sra),
    .o_result (alu_result),
    .o_cmp    (alu_cmp),
    .o_zero   (alu_zero),
    .o_add_r  (alu_add_r)
  );

endmodule

//--- testbench/exec_unit_assert.sv
`timescale 1ns/1ns

module exec_unit_assert (
  input logic i_clock,
  input logic i_reset,
  input logic o_valid,
  input logic o_mem_ren,
  input logic o_mem_wen,
  input logic o_reg_wen,
  input logic o_csr_wen,
  input logic o_jump,
  input logic o_illegal
);

  // valid lasts one cycle at most.
  valid_single_cycle: assert property (@(posedge i_clock) disable iff (i_reset)
    o_valid |=> !o_valid)
    else $error("o_valid high for two cycles");

  enables_need_valid: assert property (@(posedge i_clock) disable iff (i_reset)
    !o_valid |-> !(o_mem_ren || o_mem_wen || o_reg_wen || o_csr_wen || o_jump || o_illegal))
    else $error("enable active while o_valid is low");

  read_write_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
    !(o_mem_ren && o_mem_wen))
    else $error("memory read and write at once");

endmodule

bind exec_stage exec_unit_assert u_assert (.*);

//--- testbench/exec_unit_tb.sv
`timescale 1ns/1ns

module exec_unit_tb;

  import exec_pkg::*;

  localparam int   MAX_TESTS = 64;
  localparam word_t PC      = 32'h0000_0100;
  localparam word_t TRAP    = 32'h8000_0000;

  // enable bits: reg_wen, mem_ren, mem_wen, csr_wen, fencei, illegal.
  localparam logic [5:0] F_REG = 6'b100000;
  localparam logic [5:0] F_REN = 6'b010000;
  localparam logic [5:0] F_WEN = 6'b001000;
  localparam logic [5:0] F_CSR = 6'b000100;
  localparam logic [5:0] F_FCI = 6'b000010;
  localparam logic [5:0] F_ILL = 6'b000001;

  logic      i_clock;
  logic      i_reset;
  logic      i_valid;
  word_t     i_instr;
  word_t     i_pc;
  word_t     i_rs1_data;
  word_t     i_rs2_data;
  word_t     i_csr_data;
  word_t     i_trap_pc;
  logic      o_valid;
  word_t     o_result;
  word_t     o_mem_addr;
  word_t     o_mem_wdata;
  logic      o_mem_ren;
  logic      o_mem_wen;
  logic [3:0] o_mem_wmask;
  funct3_t   o_mem_read_t;
  logic      o_reg_wen;
  reg_idx_t  o_rd;
  logic      o_csr_wen;
  csr_kind_t o_csr_kind;
  logic      o_jump;
  word_t     o_target;
  logic      o_fencei;
  logic      o_illegal;
  word_t     o_pc;

  // stimulus and expected values, one row per test.
  word_t      t_instr  [MAX_TESTS];
  word_t      t_pc     [MAX_TESTS];
  word_t      t_rs1    [MAX_TESTS];
  word_t      t_rs2    [MAX_TESTS];
  word_t      t_csr    [MAX_TESTS];
  word_t      t_trap   [MAX_TESTS];
  word_t      t_result [MAX_TESTS];
  logic       t_chk_res[MAX_TESTS];
  word_t      t_addr   [MAX_TESTS];
  word_t      t_target [MAX_TESTS];
  logic       t_jump   [MAX_TESTS];
  logic [3:0] t_mask   [MAX_TESTS];
  logic [5:0] t_flags  [MAX_TESTS];

  int   num_tests = 0;
  int   errors = 0;
  int   passed = 0;
  int   seed = 25388;
  logic table_ready = 1'b0;

  exec_unit u_exec_unit (.*);

  initial begin
    i_clock = 1'b0;
    forever #10 i_clock = ~i_clock;
  end

  function automatic word_t r_type_word(input logic [6:0] f7, input reg_idx_t rs2,
                                        input reg_idx_t rs1, input funct3_t f3,
                                        input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic word_t i_type_word(input logic [11:0] imm, input reg_idx_t rs1,
                                        input funct3_t f3, input reg_idx_t rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type_word(input logic [11:0] imm, input reg_idx_t rs2,
                                        input reg_idx_t rs1, input funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic word_t b_type_word(input logic [12:0] imm, input funct3_t f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic word_t j_type_word(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic push_entry(input word_t instr, input word_t rs1, input word_t rs2,
                            input word_t csr, input word_t res, input logic chk_res,
                            input word_t addr, input word_t target, input logic jump,
                            input logic [3:0] mask, input logic [5:0] flags);
    t_instr[num_tests]   = instr;
    t_pc[num_tests]      = PC;
    t_rs1[num_tests]     = rs1;
    t_rs2[num_tests]     = rs2;
    t_csr[num_tests]     = csr;
    t_trap[num_tests]    = TRAP;
    t_result[num_tests]  = res;
    t_chk_res[num_tests] = chk_res;
    t_addr[num_tests]    = addr;
    t_target[num_tests]  = target;
    t_jump[num_tests]    = jump;
    t_mask[num_tests]    = mask;
    t_flags[num_tests]   = flags;
    num_tests++;
  endtask

  task automatic alu_row(input word_t instr, input word_t rs1, input word_t rs2,
                         input word_t res);
    push_entry(instr, rs1, rs2, '0, res, 1'b1, '0, '0, 1'b0, 4'b0000, F_REG);
  endtask

  // every branch uses rs1/rs2 = x1/x2 and an offset of 16.
  task automatic branch_row(input funct3_t f3, input word_t rs1, input word_t rs2,
                            input logic taken);
    push_entry(b_type_word(13'h010, f3), rs1, rs2, '0, '0, 1'b0, '0, PC + 32'd16,
               taken, 4'b0000, 6'b000000);
  endtask

  task automatic build_table();
    word_t ra;
    word_t rb;
    // immediate forms.
    alu_row(i_type_word(12'hffd, 1, F3_ADD, 3, 7'h13), 32'd5, '0, 32'd2);
    alu_row(i_type_word(12'h0f0, 1, F3_XOR, 3, 7'h13), 32'hff, '0, 32'h0f);
    alu_row(i_type_word(12'h0ff, 1, F3_OR, 3, 7'h13), 32'hf00, '0, 32'hfff);
    alu_row(i_type_word(12'h0f0, 1, F3_AND, 3, 7'h13), 32'hff, '0, 32'hf0);
    alu_row(i_type_word(12'h004, 1, F3_SLL, 3, 7'h13), 32'd1, '0, 32'h10);
    alu_row(i_type_word(12'h004, 1, F3_SR, 3, 7'h13), 32'h8000_0000, '0, 32'h0800_0000);
    alu_row(i_type_word(12'h404, 1, F3_SR, 3, 7'h13), 32'h8000_0000, '0, 32'hf800_0000);
    alu_row(i_type_word(12'h001, 1, F3_SLT, 3, 7'h13), 32'hffff_ffff, '0, 32'd1);
    alu_row(i_type_word(12'h001, 1, F3_SLTU, 3, 7'h13), 32'hffff_ffff, '0, 32'd0);
    // register forms.
    alu_row(r_type_word(7'h00, 2, 1, F3_ADD, 3), 32'd7, 32'd8, 32'd15);
    alu_row(r_type_word(7'h20, 2, 1, F3_ADD, 3), 32'd7, 32'd8, 32'hffff_ffff);
    alu_row(r_type_word(7'h00, 2, 1, F3_SLT, 3), 32'hffff_fffe, 32'd3, 32'd1);
    alu_row(r_type_word(7'h00, 2, 1, F3_SLTU, 3), 32'hffff_fffe, 32'd3, 32'd0);
    alu_row(r_type_word(7'h00, 2, 1, F3_SR, 3), 32'h8000_0000, 32'd8, 32'h0080_0000);
    alu_row(r_type_word(7'h20, 2, 1, F3_SR, 3), 32'h8000_0000, 32'd8, 32'hff80_0000);
    alu_row(r_type_word(7'h00, 2, 1, F3_SLL, 3), 32'd3, 32'd2, 32'd12);
    // loads and stores.
    push_entry(i_type_word(12'h010, 1, 3'b010, 3, 7'h03), 32'h1000, '0, '0, '0, 1'b0,
               32'h1010, '0, 1'b0, 4'b0000, F_REG | F_REN);
    push_entry(i_type_word(12'hfff, 1, 3'b100, 3, 7'h03), 32'h1000, '0, '0, '0, 1'b0,
               32'h0fff, '0, 1'b0, 4'b0000, F_REG | F_REN);
    push_entry(s_type_word(12'h004, 2, 1, F3_SB), 32'h2000, 32'hab, '0, '0, 1'b0,
               32'h2004, '0, 1'b0, 4'b0001, F_WEN);
    push_entry(s_type_word(12'h006, 2, 1, F3_SH), 32'h2000, 32'h1234, '0, '0, 1'b0,
               32'h2006, '0, 1'b0, 4'b0011, F_WEN);
    push_entry(s_type_word(12'hffc, 2, 1, 3'b010), 32'h2000, 32'hcafe_f00d, '0, '0, 1'b0,
               32'h1ffc, '0, 1'b0, 4'b1111, F_WEN);
    // six branches, taken then not taken.
    branch_row(F3_BEQ, 32'd5, 32'd5, 1'b1);
    branch_row(F3_BEQ, 32'd5, 32'd6, 1'b0);
    branch_row(F3_BNE, 32'd5, 32'd6, 1'b1);
    branch_row(F3_BNE, 32'd5, 32'd5, 1'b0);
    branch_row(F3_BLT, 32'hffff_ffff, 32'd1, 1'b1);
    branch_row(F3_BLT, 32'd1, 32'hffff_ffff, 1'b0);
    branch_row(F3_BGE, 32'd1, 32'hffff_ffff, 1'b1);
    branch_row(F3_BGE, 32'hffff_ffff, 32'd1, 1'b0);
    branch_row(F3_BLTU, 32'd1, 32'hffff_ffff, 1'b1);
    branch_row(F3_BLTU, 32'hffff_ffff, 32'd1, 1'b0);
    branch_row(F3_BGEU, 32'hffff_ffff, 32'd1, 1'b1);
    branch_row(F3_BGEU, 32'd1, 32'hffff_ffff, 1'b0);
    // jumps and upper immediates.
    push_entry(j_type_word(21'h000020, 1), '0, '0, '0, PC + 32'd4, 1'b1, '0,
               PC + 32'h20, 1'b1, 4'b0000, F_REG);
    push_entry(i_type_word(12'h008, 1, 3'b000, 1, 7'h67), 32'h3000, '0, '0, PC + 32'd4,
               1'b1, '0, 32'h3008, 1'b1, 4'b0000, F_REG);
    alu_row({20'h12345, 5'd3, 7'h37}, '0, '0, 32'h1234_5000);
    alu_row({20'h00001, 5'd3, 7'h17}, '0, '0, PC + 32'h1000);
    // system and fence.
    push_entry(32'h0000_0073, '0, '0, '0, '0, 1'b0, '0, TRAP, 1'b1, 4'b0000,
               F_REG | F_CSR);
    push_entry(i_type_word(12'h300, 1, 3'b001, 2, 7'h73), 32'h55, '0, 32'hdead_beef,
               32'hdead_beef, 1'b1, '0, '0, 1'b0, 4'b0000, F_REG | F_CSR);
    push_entry(32'h0000_100f, '0, '0, '0, '0, 1'b0, '0, '0, 1'b0, 4'b0000, F_REG | F_FCI);
    push_entry(32'h0000_000f, '0, '0, '0, '0, 1'b0, '0, '0, 1'b0, 4'b0000, F_REG);
    push_entry(32'h0000_010b, '0, '0, '0, '0, 1'b0, '0, '0, 1'b0, 4'b0000, F_ILL);
    // random ADD, SUB and XOR rows.
    for (int k = 0; k < 9; k++) begin
      ra = $random(seed);
      rb = $random(seed);
      case (k % 3)
        0: alu_row(r_type_word(7'h00, 2, 1, F3_ADD, 4), ra, rb, ra + rb);
        1: alu_row(r_type_word(7'h20, 2, 1, F3_ADD, 4), ra, rb, ra - rb);
        default: alu_row(r_type_word(7'h00, 2, 1, F3_XOR, 4), ra, rb, ra ^ rb);
      endcase
    end
  endtask

  task automatic compare_value(input int idx, input string what, input word_t got,
                               input word_t exp);
    if (got !== exp) begin
      $display("FAILED t=%0t test %0d: %s got %h expected %h", $time, idx, what, got, exp);
      errors++;
    end
  endtask

  task automatic run_entry(input int idx);
    int waited;
    int errors_before;
    errors_before = errors;
    @(negedge i_clock);
    i_instr    = t_instr[idx];
    i_pc       = t_pc[idx];
    i_rs1_data = t_rs1[idx];
    i_rs2_data = t_rs2[idx];
    i_csr_data = t_csr[idx];
    i_trap_pc  = t_trap[idx];
    i_valid    = 1'b1;
    @(negedge i_clock);
    i_valid = 1'b0;
    waited  = 1;
    while (!o_valid && waited < 4) begin
      @(negedge i_clock);
      waited++;
    end
    if (!o_valid) begin
      $display("test %0d: o_valid never came after the strobe", idx);
      errors++;
    end else begin
      compare_value(idx, "latency", waited, 1);
      compare_value(idx, "enables", {26'b0, o_reg_wen, o_mem_ren, o_mem_wen, o_csr_wen,
                    o_fencei, o_illegal}, {26'b0, t_flags[idx]});
      compare_value(idx, "jump", {31'b0, o_jump}, {31'b0, t_jump[idx]});
      compare_value(idx, "mask", {28'b0, o_mem_wmask}, {28'b0, t_mask[idx]});
      compare_value(idx, "pc", o_pc, t_pc[idx]);
      if (t_chk_res[idx]) begin
        compare_value(idx, "result", o_result, t_result[idx]);
      end
      if (t_jump[idx]) begin
        compare_value(idx, "target", o_target, t_target[idx]);
      end
      if (t_flags[idx][4] || t_flags[idx][3]) begin
        compare_value(idx, "address", o_mem_addr, t_addr[idx]);
      end
      if (t_flags[idx][3]) begin
        compare_value(idx, "write data", o_mem_wdata, t_rs2[idx]);
      end
      if (t_flags[idx][4]) begin
        compare_value(idx, "read type", {29'b0, o_mem_read_t}, {29'b0, t_instr[idx][14:12]});
      end
      if (t_flags[idx][5]) begin
        compare_value(idx, "rd", {27'b0, o_rd}, {27'b0, t_instr[idx][11:7]});
      end
      if (t_flags[idx][2]) begin
        compare_value(idx, "csr kind", {30'b0, o_csr_kind}, {30'b0, t_instr[idx][13:12]});
      end
    end
    @(negedge i_clock);
    if (errors == errors_before) begin
      passed++;
      $display("test %0d passed", idx);
    end else begin
      $display("test %0d failed", idx);
    end
  endtask

  // a second strobe inside the output cycle must be dropped.
  task automatic check_busy_strobe();
    @(negedge i_clock);
    i_instr = t_instr[0];
    i_valid = 1'b1;
    @(negedge i_clock);
    compare_value(-1, "o_valid after strobe", {31'b0, o_valid}, 32'd1);
    @(negedge i_clock);
    i_valid = 1'b0;
    compare_value(-1, "o_valid after busy strobe", {31'b0, o_valid}, 32'd0);
    @(negedge i_clock);
    compare_value(-1, "o_valid after release", {31'b0, o_valid}, 32'd0);
    $display("busy strobe test done");
  endtask

  initial begin
    wait (table_ready);
    repeat (num_tests * 4 + 40) @(posedge i_clock);
    $display("timeout: the tests did not finish within the cycle limit");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    i_reset    = 1'b1;
    i_valid    = 1'b0;
    i_instr    = '0;
    i_pc       = '0;
    i_rs1_data = '0;
    i_rs2_data = '0;
    i_csr_data = '0;
    i_trap_pc  = '0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge i_clock);
    @(negedge i_clock);
    i_reset = 1'b0;
    compare_value(-1, "o_valid after reset", {31'b0, o_valid}, 32'd0);
    for (int i = 0; i < num_tests; i++) begin
      run_entry(i);
    end
    check_busy_strobe();
    $display("tests run %0d, passed %0d, failed %0d, errors %0d", num_tests, passed,
             num_tests - passed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- exec_unit.f
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_decode.sv
hdl/exec_stage.sv
hdl/exec_unit.sv
testbench/exec_unit_assert.sv
testbench/exec_unit_tb.sv

//--- Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= exec_unit_tb
FILELIST ?= exec_unit.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q ">>> PASS" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
